/* wb_mem_subsys.f */
wb_mem_pkg.sv
wb_cmd_stage.sv
wb_mem.sv
rd_align_stage.sv
wb_mem_subsys.sv
tb_checker.sv
tb_wb_mem_subsys.sv

/* Makefile */
TOP = tb_wb_mem_subsys

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f wb_mem_subsys.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only --timing -f wb_mem_subsys.f --top-module wb_mem_subsys

clean:
	rm -rf obj_dir sim.log

/* tb_wb_mem_subsys.sv */
`timescale 1ns/10ps

module tb_wb_mem_subsys;

    localparam int CLK_PERIOD  = 40;
    localparam int TIMEOUT_CYC = 50;  // per wait
    localparam int N_RANDOM    = 40;

    // one stimulus line, with its expected response where written by hand
    typedef struct {
        string                 name;
        wb_mem_pkg::host_cmd_t cmd;
        bit                    has_exp;
        wb_mem_pkg::host_rsp_t exp;
    } stim_t;

    logic                  clk;
    logic                  rst_n_i;
    logic                  cmd_valid_i;
    wb_mem_pkg::host_cmd_t cmd_i;
    logic                  busy_o;
    logic                  rsp_valid_o;
    wb_mem_pkg::host_rsp_t rsp_o;

    stim_t       tbl[$];
    int          val_errs;
    int          proto_errs;
    int          pending;
    int          timeouts;
    bit          abort;     // set on a timeout, skips the rest of the run
    logic [31:0] rnd;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    wb_mem_subsys #(
        .EDGE        (0),
        .DEPTH_WORDS (1024)
    ) i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    tb_checker #(
        .DEPTH_WORDS (1024)
    ) i_chk (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .busy_i       (busy_o),
        .rsp_valid_i  (rsp_valid_o),
        .rsp_i        (rsp_o),
        .val_errs_o   (val_errs),
        .proto_errs_o (proto_errs),
        .pending_o    (pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_entry(input string name, input bit we, input bit sgn,
                             input wb_mem_pkg::sel_t sel, input wb_mem_pkg::adr_t adr,
                             input wb_mem_pkg::word_t dat, input wb_mem_pkg::word_t exp_data);
        stim_t s;
        s.name              = name;
        s.cmd.we            = we;
        s.cmd.signed_ld     = sgn;
        s.cmd.sel           = sel;
        s.cmd.adr           = adr;
        s.cmd.dat           = dat;
        s.has_exp           = 1'b1;
        s.exp.is_write      = we;  // writes answer with is_write set
        s.exp.data          = exp_data;
        tbl.push_back(s);
    endtask

    // name, we, signed, sel, adr, write data, expected data
    task automatic build_table();
        add_entry("wr_full",       1, 0, 4'hf, 16'h0001, 32'h8a7b6c5d, 32'h00000000);
        add_entry("rd_full",       0, 0, 4'hf, 16'h0001, 32'h0,        32'h8a7b6c5d);
        add_entry("wr_lane1",      1, 0, 4'h2, 16'h0001, 32'h0000ee00, 32'h00000000);
        add_entry("wr_upper_half", 1, 0, 4'hc, 16'h0001, 32'h12340000, 32'h00000000);
        add_entry("rd_merged",     0, 0, 4'hf, 16'h0001, 32'h0,        32'h1234ee5d);
        add_entry("wr_word3",      1, 0, 4'hf, 16'h0003, 32'hf1827364, 32'h00000000);
        add_entry("rd_ub0",        0, 0, 4'h1, 16'h0003, 32'h0,        32'h00000064);
        add_entry("rd_ub1",        0, 0, 4'h2, 16'h0003, 32'h0,        32'h00000073);
        add_entry("rd_ub2",        0, 0, 4'h4, 16'h0003, 32'h0,        32'h00000082);
        add_entry("rd_ub3",        0, 0, 4'h8, 16'h0003, 32'h0,        32'h000000f1);
        add_entry("rd_uh_lo",      0, 0, 4'h3, 16'h0003, 32'h0,        32'h00007364);
        add_entry("rd_uh_hi",      0, 0, 4'hc, 16'h0003, 32'h0,        32'h0000f182);
        add_entry("rd_sb3",        0, 1, 4'h8, 16'h0003, 32'h0,        32'hfffffff1);
        add_entry("rd_sb1",        0, 1, 4'h2, 16'h0003, 32'h0,        32'h00000073);
        add_entry("rd_sh_hi",      0, 1, 4'hc, 16'h0003, 32'h0,        32'hfffff182);
        add_entry("rd_sh_lo",      0, 1, 4'h3, 16'h0003, 32'h0,        32'h00007364);
        add_entry("rd_sh_mid",     0, 1, 4'h6, 16'h0003, 32'h0,        32'hffff8273);
        add_entry("rd_unwritten",  0, 0, 4'hf, 16'h0040, 32'h0,        32'h00000000);
        add_entry("rd_no_sel",     0, 1, 4'h0, 16'h0003, 32'h0,        32'h00000000);
        add_entry("rd_gap",        0, 0, 4'h9, 16'h0003, 32'h0,        32'hf1000064);
        add_entry("rd_gap_signed", 0, 1, 4'h5, 16'h0003, 32'h0,        32'hff820064);
    endtask

    // called on a falling edge
    task automatic wait_not_busy(input string name);
        int n;
        n = 0;
        while (busy_o && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            $display("Timeout: busy_o stayed high before %s", name);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    task automatic wait_response(input string name);
        int n;
        n = 0;
        while (!rsp_valid_o && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_valid_o) begin
            $display("Timeout: no response pulse for %s", name);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    // every accepted command must come back before the run ends
    task automatic wait_drain();
        int n;
        n = 0;
        while (pending != 0 && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("Missing response: %0d commands never completed", pending);
            timeouts++;
        end
    endtask

    // one strobe, taken at the rising edge in between
    task automatic issue(input stim_t s);
        cmd_i       = s.cmd;
        cmd_valid_i = 1'b1;
        i_chk.expect_next(s.name, s.has_exp, s.exp);
        @(negedge clk);
        cmd_valid_i = 1'b0;
    endtask

    initial begin
        stim_t s;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        timeouts    = 0;
        abort       = 1'b0;
        build_table();
        repeat (2) @(posedge clk);  // two rising edges in reset
        @(negedge clk);
        rst_n_i = 1'b1;

        foreach (tbl[i]) begin
            if (!abort) wait_not_busy(tbl[i].name);
            if (!abort) issue(tbl[i]);
            if (!abort) wait_response(tbl[i].name);
        end

        // back to back, next strobe as soon as busy_o drops
        rnd = 32'hedbb0f37;
        for (int i = 0; i < N_RANDOM && !abort; i++) begin
            rnd             = xorshift32(rnd);
            s.name          = $sformatf("rand_%0d", i);
            s.cmd.we        = rnd[0];
            s.cmd.signed_ld = rnd[1];
            s.cmd.sel       = rnd[5:2];
            s.cmd.adr       = {12'h000, rnd[9:6]};  // within 16 words
            rnd             = xorshift32(rnd);
            s.cmd.dat       = rnd;
            s.has_exp       = 1'b0;
            s.exp           = '0;
            wait_not_busy(s.name);
            if (!abort) issue(s);
        end
        if (!abort) wait_drain();

        $display("errors: value %0d, protocol %0d, timeout %0d", val_errs, proto_errs, timeouts);
        if (val_errs + proto_errs + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/10ps

module tb_checker #(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   cmd_valid_i,
    input  wb_mem_pkg::host_cmd_t  cmd_i,
    input  logic                   busy_i,
    input  logic                   rsp_valid_i,
    input  wb_mem_pkg::host_rsp_t  rsp_i,
    output int                     val_errs_o,    // wrong response values
    output int                     proto_errs_o,  // pulses and handshakes out of place
    output int                     pending_o      // accepted commands still waiting
);

    // names and table values noted by the stimulus, in issue order
    string                 note_name_q[$];
    bit                    note_has_q[$];
    wb_mem_pkg::host_rsp_t note_exp_q[$];

    // accepted commands waiting for their response
    wb_mem_pkg::host_cmd_t cmd_q[$];
    string                 name_q[$];
    bit                    has_q[$];
    wb_mem_pkg::host_rsp_t exp_q[$];

    wb_mem_pkg::word_t model [int];  // sparse model, missing entries read zero
    int val_errs   = 0;
    int proto_errs = 0;
    int pending    = 0;

    assign val_errs_o   = val_errs;
    assign proto_errs_o = proto_errs;
    assign pending_o    = pending;

    // called by the stimulus just before it raises the strobe
    task automatic expect_next(input string name, input bit has_exp,
                               input wb_mem_pkg::host_rsp_t exp);
        note_name_q.push_back(name);
        note_has_q.push_back(has_exp);
        note_exp_q.push_back(exp);
    endtask

    // load rule: lowest selected byte to bit 0, keep up to the highest, extend above
    function automatic wb_mem_pkg::word_t load_result(input wb_mem_pkg::word_t stored,
                                                     input wb_mem_pkg::sel_t sel,
                                                     input bit sgn);
        int                lo;
        int                hi;
        int                nbits;
        wb_mem_pkg::word_t raw;
        wb_mem_pkg::word_t res;
        lo  = -1;
        hi  = -1;
        raw = '0;
        for (int b = 0; b < wb_mem_pkg::NBYTES; b++) begin
            if (sel[b]) begin
                raw[8*b +: 8] = stored[8*b +: 8];  // gap lanes stay zero
                if (lo < 0) lo = b;
                hi = b;
            end
        end
        if (lo < 0) return '0;  // empty select loads nothing
        res   = raw >> (8 * lo);
        nbits = 8 * (hi - lo + 1);
        for (int i = nbits; i < 32; i++) begin
            res[i] = sgn ? res[nbits-1] : 1'b0;
        end
        return res;
    endfunction

    // carries one command into the model, gives back the response it should produce
    function automatic wb_mem_pkg::host_rsp_t apply_to_model(input wb_mem_pkg::host_cmd_t c);
        int                    key;
        wb_mem_pkg::word_t     cur;
        wb_mem_pkg::host_rsp_t r;
        key = int'(c.adr) % DEPTH_WORDS;  // memory keeps the low address bits
        cur = model.exists(key) ? model[key] : '0;
        r   = '0;
        if (c.we) begin
            for (int b = 0; b < wb_mem_pkg::NBYTES; b++) begin
                if (c.sel[b]) cur[8*b +: 8] = c.dat[8*b +: 8];
            end
            model[key] = cur;
            r.is_write = 1'b1;
        end else begin
            r.data = load_result(cur, c.sel, c.signed_ld);
        end
        return r;
    endfunction

    // outputs are registered, so the pre-edge values read here are stable
    always @(posedge clk) begin
        wb_mem_pkg::host_cmd_t c;
        wb_mem_pkg::host_rsp_t exp;
        if (rst_n_i) begin
            if (rsp_valid_i) begin
                if (cmd_q.size() == 0) begin
                    $display("Error: response pulse with no command outstanding");
                    proto_errs++;
                end else begin
                    c   = cmd_q.pop_front();
                    exp = apply_to_model(c);
                    if (rsp_i !== exp) begin
                        // is_write, then data
                        $display("Fail %s: expected %0b %08h, actual %0b %08h",
                                 name_q[0], exp.is_write, exp.data,
                                 rsp_i.is_write, rsp_i.data);
                        val_errs++;
                    end
                    if (has_q[0] && rsp_i !== exp_q[0]) begin  // hand-written table value
                        $display("Fail %s (table): expected %0b %08h, actual %0b %08h",
                                 name_q[0], exp_q[0].is_write, exp_q[0].data,
                                 rsp_i.is_write, rsp_i.data);
                        val_errs++;
                    end
                    void'(name_q.pop_front());
                    void'(has_q.pop_front());
                    void'(exp_q.pop_front());
                end
            end
            if (cmd_valid_i && !busy_i) begin  // accepting edge
                if (cmd_q.size() != 0) begin
                    $display("Error: command accepted while a response is still outstanding");
                    proto_errs++;
                end
                if (note_name_q.size() == 0) begin
                    name_q.push_back("unnamed");
                    has_q.push_back(1'b0);
                    exp_q.push_back('0);
                end else begin
                    name_q.push_back(note_name_q.pop_front());
                    has_q.push_back(note_has_q.pop_front());
                    exp_q.push_back(note_exp_q.pop_front());
                end
                cmd_q.push_back(cmd_i);
            end
            pending = cmd_q.size();
        end
    end

endmodule

/* wb_mem_subsys.sv */
`timescale 1ns/10ps

module wb_mem_subsys #(
    parameter int EDGE        = 0,     // memory clock edge, 0 falling, 1 rising
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   cmd_valid_i,
    input  wb_mem_pkg::host_cmd_t  cmd_i,
    output logic                   busy_o,
    output logic                   rsp_valid_o,
    output wb_mem_pkg::host_rsp_t  rsp_o
);

    wb_mem_pkg::wb_req_t wb_req;     // command stage to memory
    wb_mem_pkg::ld_tag_t ld_tag;     // access info, stable during the cycle
    wb_mem_pkg::word_t   wb_rd_dat;  // memory read word
    logic                wb_ack;
    logic                ack_taken;  // done pulse to the alignment stage

    // command stage, runs the bus cycle
    wb_cmd_stage i_cmd_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .ack_i       (wb_ack),
        .req_o       (wb_req),
        .tag_o       (ld_tag),
        .ack_taken_o (ack_taken),
        .busy_o      (busy_o)
    );

    // byte select word memory
    wb_mem #(
        .EDGE        (EDGE),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_mem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (wb_req),
        .ack_o   (wb_ack),
        .dat_o   (wb_rd_dat)
    );

    // load result alignment and response register
    rd_align_stage i_rd_align (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ack_taken_i (ack_taken),
        .tag_i       (ld_tag),
        .dat_i       (wb_rd_dat),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

/* rd_align_stage.sv */
`timescale 1ns/10ps

module rd_align_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   ack_taken_i,  // read word valid at this edge
    input  wb_mem_pkg::ld_tag_t    tag_i,
    input  wb_mem_pkg::word_t      dat_i,        // raw word, unselected lanes zero
    output logic                   rsp_valid_o,
    output wb_mem_pkg::host_rsp_t  rsp_o
);

    localparam int LW = $clog2(wb_mem_pkg::NBYTES);  // lane index width

    logic [LW-1:0]     lo_lane;  // lowest selected byte
    logic [LW-1:0]     hi_lane;  // highest selected byte
    logic [LW-1:0]     span;     // hi - lo, top byte of the result
    logic [7:0]        fill;     // byte used above the span
    wb_mem_pkg::word_t shifted;
    wb_mem_pkg::word_t aligned;

    // find lowest and highest selected lane
    always_comb begin
        lo_lane = '0;
        hi_lane = '0;
        for (int b = wb_mem_pkg::NBYTES - 1; b >= 0; b--) begin
            if (tag_i.sel[b]) lo_lane = LW'(b);  // last hit wins, so the lowest one
        end
        for (int b = 0; b < wb_mem_pkg::NBYTES; b++) begin
            if (tag_i.sel[b]) hi_lane = LW'(b);
        end
    end

    assign span    = hi_lane - lo_lane;
    assign shifted = dat_i >> {lo_lane, 3'b000};  // lowest selected byte to bit 0

    // sign source is the msb of the highest selected byte after the shift
    assign fill = (tag_i.signed_ld && shifted[{span, 3'b111}]) ? 8'hff : 8'h00;

    // keep the span, fill above it
    always_comb begin
        aligned = shifted;
        for (int b = 0; b < wb_mem_pkg::NBYTES; b++) begin
            if (b > int'(span)) aligned[8*b +: 8] = fill;
        end
        if (tag_i.sel == '0) aligned = '0;  // nothing selected, nothing loaded
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= ack_taken_i;  // one-cycle pulse per command
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (ack_taken_i) begin
            rsp_o.is_write <= tag_i.we;
            rsp_o.data     <= tag_i.we ? '0 : aligned;  // writes return zero
        end
    end

endmodule

/* wb_mem.sv */
`timescale 1ns/10ps

module wb_mem #(
    parameter int EDGE        = 0,     // 1: rising clk, 0: falling clk
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  wb_mem_pkg::wb_req_t  req_i,
    output logic                 ack_o,
    output wb_mem_pkg::word_t    dat_o  // selected lanes only, rest zero
);

    localparam int AW = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;  // index width

    wb_mem_pkg::word_t mem [DEPTH_WORDS];

    logic          mem_clk;  // clock on the chosen edge
    logic          en;
    logic          wr_en;
    logic [AW-1:0] idx;

    // falling edge gives the memory half a cycle, so ack is back before the next rising edge
    assign mem_clk = (EDGE != 0) ? clk : ~clk;

    assign en    = req_i.cyc & req_i.stb;
    assign wr_en = en & req_i.we;
    assign idx   = req_i.adr[AW-1:0];  // upper address bits ignored

    // contents start out as zero
    initial begin
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // read port, unselected lanes come back zero
    always_ff @(posedge mem_clk) begin
        for (int b = 0; b < wb_mem_pkg::NBYTES; b++) begin
            if (req_i.sel[b]) dat_o[8*b +: 8] <= mem[idx][8*b +: 8];
            else              dat_o[8*b +: 8] <= 8'h00;
        end
    end

    // write port, byte lanes individually
    always_ff @(posedge mem_clk) begin
        if (wr_en) begin
            for (int b = 0; b < wb_mem_pkg::NBYTES; b++) begin
                if (req_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
    end

    // ack follows the open cycle on each active edge
    always_ff @(posedge mem_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= en;  // held while cyc/stb stay up
        end
    end

endmodule

/* wb_cmd_stage.sv */
`timescale 1ns/10ps

module wb_cmd_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   cmd_valid_i,  // host strobe
    input  wb_mem_pkg::host_cmd_t  cmd_i,
    input  logic                   ack_i,        // from the memory
    output wb_mem_pkg::wb_req_t    req_o,
    output wb_mem_pkg::ld_tag_t    tag_o,        // access info for the alignment stage
    output logic                   ack_taken_o,  // high at the edge the ack is consumed
    output logic                   busy_o
);

    // bus cycle sequencer
    typedef enum logic [1:0] {
        IDLE,  // nothing open
        BUS,   // cyc/stb up, waiting on ack
        GAP    // one cycle with cyc low so the held ack can drop
    } state_t;

    state_t                state_q, state_d;
    wb_mem_pkg::host_cmd_t cmd_q;  // command being carried out
    logic                  accept;

    // strobe only counts while nothing is in flight
    assign accept = cmd_valid_i & ~busy_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (accept) state_d = BUS;
            BUS:  if (ack_i)  state_d = GAP;  // first ack seen at a rising edge
            GAP: begin
                // cyc has been low for the last full cycle, a new command may start
                if (accept) state_d = BUS;
                else        state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // command payload, held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end
    end

    // bus side
    assign req_o.cyc = (state_q == BUS);
    assign req_o.stb = (state_q == BUS);  // single beat, stb tracks cyc
    assign req_o.we  = cmd_q.we;
    assign req_o.sel = cmd_q.sel;
    assign req_o.adr = cmd_q.adr;
    assign req_o.dat = cmd_q.dat;

    // alignment stage side
    assign tag_o.we        = cmd_q.we;
    assign tag_o.signed_ld = cmd_q.signed_ld;
    assign tag_o.sel       = cmd_q.sel;

    // done pulse, the response register loads on this same edge
    assign ack_taken_o = (state_q == BUS) & ack_i;

    // busy drops with the edge that issues the response pulse
    assign busy_o = (state_q == BUS);

endmodule

/* wb_mem_pkg.sv */
package wb_mem_pkg;

    localparam int NBYTES = 4;  // bytes per data word

    // basic vectors
    typedef logic [8*NBYTES-1:0] word_t;  // one data word
    typedef logic [15:0]         adr_t;   // word address, memory keeps the low bits
    typedef logic [NBYTES-1:0]   sel_t;   // one select bit per byte lane

    // command as the host hands it over
    typedef struct packed {
        logic  we;         // write
        logic  signed_ld;  // sign-extend the load result
        sel_t  sel;
        adr_t  adr;
        word_t dat;        // write data, don't care on reads
    } host_cmd_t;

    // classic wishbone request, master side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        adr_t  adr;
        word_t dat;
    } wb_req_t;

    // what the alignment stage needs to know about the access in flight
    typedef struct packed {
        logic we;
        logic signed_ld;
        sel_t sel;
    } ld_tag_t;

    // response back to the host
    typedef struct packed {
        logic  is_write;
        word_t data;  // aligned load result, zero for writes
    } host_rsp_t;

endpackage
